// ==== Bender.yml ====
package:
  name: icache

sources:
  - icache_bus_pkg.sv
  - icache_geom_pkg.sv
  - icache_ram.sv
  - icache_refill.sv
  - icache.sv
  - icache_top.sv
  - target: simulation
    files:
      - tb_icache_top.sv

// ==== filelist.f ====
icache_bus_pkg.sv
icache_geom_pkg.sv
icache_ram.sv
icache_refill.sv
icache.sv
icache_top.sv
tb_icache_top.sv

// ==== icache.sv ====
`default_nettype none

module icache
    import icache_bus_pkg::*;
    import icache_geom_pkg::*;
#(
    parameter int IDX_W = DEF_IDX_W
) (
    input  logic                        i_clk,
    input  logic                        i_rst,
    input  logic                        i_req,
    input  logic                        i_submit,
    input  logic                        i_flush,
    input  logic [RW-1:0]               i_addr,
    output logic                        o_ack,
    output logic [I_SIZE-1:0]           o_data,

    // Refill unit.
    output logic                        o_refill_start,
    output logic [RW-OFF_W-1:0]         o_line_addr,
    input  logic                        i_refill_busy,
    input  logic                        i_fetch_end,
    input  logic                        i_bus_err,
    input  icache_line_u                i_fill_line,

    // Line storage.
    output logic [IDX_W-1:0]            o_ram_index,
    output logic                        o_ram_we,
    output logic                        o_ram_clear,
    output logic [RW-IDX_W-OFF_W-1:0]   o_ram_tag,
    output icache_line_u                o_ram_line,
    input  logic [RW-IDX_W-OFF_W-1:0]   i_ram_tag,
    input  icache_line_u                i_ram_line,
    input  logic                        i_ram_valid
);

    localparam int TAG_W = RW - IDX_W - OFF_W;

    logic              pending;
    logic [RW-1:0]     pending_addr;
    logic [RW-1:0]     next_addr;
    logic [RW-1:0]     read_addr;
    logic              read_valid;
    logic              accept_ok;
    logic              accept;
    logic              flush_q;
    logic              cancelled;
    logic              line_ok;
    logic              hit;
    logic              miss;
    logic              ram_we;
    logic [TAG_W-1:0]  read_tag;
    logic [IDX_W-1:0]  read_index;
    logic [IDX_W-1:0]  next_index;
    logic [OFF_W-1:0]  read_off;
    icache_line_u      sel_line;

    // A held submit goes ahead of the one on the port.
    assign next_addr = pending ? pending_addr : i_addr;

    assign accept_ok = i_req & ~i_refill_busy & ~miss;
    assign accept = accept_ok & (pending | i_submit);

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            pending <= 1'b0;
        end else if (i_submit && (!accept_ok || pending)) begin
            pending <= 1'b1;
        end else if (accept_ok) begin
            pending <= 1'b0;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_submit && (!accept_ok || pending)) begin
            pending_addr <= i_addr;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            read_valid <= 1'b0;
        end else begin
            read_valid <= accept;
        end
    end

    // Held steady through a whole refill since nothing is accepted then.
    always_ff @(posedge i_clk) begin
        if (accept) begin
            read_addr <= next_addr;
        end
    end

    assign read_tag = read_addr[RW-1 -: TAG_W];
    assign read_index = read_addr[OFF_W +: IDX_W];
    assign read_off = read_addr[OFF_W-1:0];
    assign next_index = next_addr[OFF_W +: IDX_W];

    // The RAM still shows old valid bits right after a flush.
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            flush_q <= 1'b0;
        end else begin
            flush_q <= i_flush;
        end
    end

    assign line_ok = i_ram_valid & (i_ram_tag == read_tag) & ~flush_q;
    assign hit = read_valid & line_ok;
    assign miss = read_valid & ~line_ok;

    // A flush during a refill still returns the data but does not keep the line.
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            cancelled <= 1'b0;
        end else if (i_fetch_end) begin
            cancelled <= 1'b0;
        end else if (i_flush && (i_refill_busy || miss)) begin
            cancelled <= 1'b1;
        end
    end

    assign ram_we = i_fetch_end & ~cancelled & ~i_flush & ~i_bus_err;

    assign o_refill_start = miss;
    assign o_line_addr = read_addr[RW-1:OFF_W];

    assign o_ram_we = ram_we;
    assign o_ram_clear = i_flush;
    assign o_ram_index = ram_we ? read_index : next_index;
    assign o_ram_tag = read_tag;
    assign o_ram_line = i_fill_line;

    assign o_ack = hit | i_fetch_end;

    // instruction pick
    assign sel_line = i_fetch_end ? i_fill_line : i_ram_line;
    assign o_data = sel_line.instr[read_off];

endmodule

`default_nettype wire

// ==== icache_bus_pkg.sv ====
`default_nettype none

// Refill bus and fetch port dimensions.
package icache_bus_pkg;

    // Bus data word and fetch address width.
    parameter int RW = 16;

    // One instruction as returned to the fetch stage.
    parameter int I_SIZE = 32;

    // Bus word address holds the line address with the beat number below it.
    parameter int BUS_AW = 17;

    // Bus beats needed to fill one line.
    parameter int BEATS = 8;

    // Beat counter width.
    parameter int BEAT_W = 3;

endpackage

`default_nettype wire

// ==== icache_geom_pkg.sv ====
`default_nettype none

// Cache line geometry and the two views of a line.
package icache_geom_pkg;

    import icache_bus_pkg::*;

    // One line holds a full burst.
    parameter int LINE_W = BEATS * RW;

    // Instructions per line and the offset that selects one.
    parameter int INSTRS = LINE_W / I_SIZE;
    parameter int OFF_W = 2;

    // Number of index bits unless the top level says otherwise.
    parameter int DEF_IDX_W = 5;

    // Refill writes the line beat by beat and readout picks one instruction.
    // Beat 0 and instruction 0 sit in the low bits.
    typedef union packed {
        logic [BEATS-1:0][RW-1:0]      beat;
        logic [INSTRS-1:0][I_SIZE-1:0] instr;
    } icache_line_u;

endpackage

`default_nettype wire

// ==== icache_ram.sv ====
`default_nettype none

module icache_ram
    import icache_bus_pkg::*;
    import icache_geom_pkg::*;
#(
    parameter int IDX_W = DEF_IDX_W
) (
    input  logic                        i_clk,
    input  logic                        i_rst,
    input  logic                        i_clear,
    input  logic [IDX_W-1:0]            i_index,
    input  logic                        i_we,
    input  logic [RW-IDX_W-OFF_W-1:0]   i_tag,
    input  icache_line_u                i_line,
    output logic [RW-IDX_W-OFF_W-1:0]   o_tag,
    output icache_line_u                o_line,
    output logic                        o_valid
);

    localparam int TAG_W = RW - IDX_W - OFF_W;
    localparam int ENTRIES = 1 << IDX_W;

    logic [TAG_W-1:0] tag_mem [ENTRIES];
    icache_line_u     line_mem [ENTRIES];
    logic [ENTRIES-1:0] valid;

    // Tag and data arrays are read one cycle after the index.
    always_ff @(posedge i_clk) begin
        if (i_we) begin
            tag_mem[i_index] <= i_tag;
            line_mem[i_index] <= i_line;
        end
        o_tag <= tag_mem[i_index];
        o_line <= line_mem[i_index];
    end

    // Clear wins over a write in the same cycle.
    always_ff @(posedge i_clk) begin
        if (i_rst || i_clear) begin
            valid <= '0;
        end else if (i_we) begin
            valid[i_index] <= 1'b1;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= valid[i_index];
        end
    end

endmodule

`default_nettype wire

// ==== icache_refill.sv ====
`default_nettype none

module icache_refill
    import icache_bus_pkg::*;
    import icache_geom_pkg::*;
#(
    parameter int IDX_W = DEF_IDX_W
) (
    input  logic                    i_clk,
    input  logic                    i_rst,
    input  logic                    i_start,
    input  logic [RW-OFF_W-1:0]     i_line_addr,
    input  logic [RW-1:0]           i_wb_dat,
    input  logic                    i_wb_ack,
    input  logic                    i_wb_err,
    output logic                    o_wb_cyc,
    output logic                    o_wb_stb,
    output logic [BUS_AW-1:0]       o_wb_adr,
    output logic                    o_busy,
    output logic                    o_fetch_end,
    output icache_line_u            o_line,
    output logic                    o_bus_err
);

    localparam int TAG_W = RW - IDX_W - OFF_W;
    localparam int LA_W = TAG_W + IDX_W;

    logic [LA_W-1:0]   line_addr;
    logic [BEAT_W-1:0] beat_cnt;
    logic              beat_done;
    logic              err_seen;
    icache_line_u      collect;

    // A beat completes on ack or err while the cycle is open.
    assign beat_done = o_wb_cyc & o_wb_stb & (i_wb_ack | i_wb_err);
    assign o_fetch_end = beat_done & (beat_cnt == BEAT_W'(BEATS - 1));

    assign o_wb_adr = {line_addr, beat_cnt};
    assign o_busy = o_wb_cyc;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_wb_cyc <= 1'b0;
            o_wb_stb <= 1'b0;
            beat_cnt <= '0;
        end else if (o_fetch_end) begin
            o_wb_cyc <= 1'b0;
            o_wb_stb <= 1'b0;
            beat_cnt <= '0;
        end else if (beat_done) begin
            beat_cnt <= beat_cnt + 1'b1;
        end else if (i_start) begin
            o_wb_cyc <= 1'b1;
            o_wb_stb <= 1'b1;
            beat_cnt <= '0;
        end
    end

    // Sticky error for the whole burst.
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            err_seen <= 1'b0;
        end else if (i_start && !o_wb_cyc) begin
            err_seen <= 1'b0;
        end else if (beat_done) begin
            err_seen <= err_seen | i_wb_err;
        end
    end

    assign o_bus_err = err_seen | (o_fetch_end & i_wb_err);

    always_ff @(posedge i_clk) begin
        if (i_start && !o_wb_cyc) begin
            line_addr <= i_line_addr;
        end
    end

    always_ff @(posedge i_clk) begin
        if (beat_done) begin
            collect.beat[beat_cnt] <= i_wb_dat;
        end
    end

    // Last beat goes straight from the bus into the line.
    always_comb begin
        o_line = collect;
        o_line.beat[BEATS-1] = i_wb_dat;
    end

endmodule

`default_nettype wire

// ==== icache_top.sv ====
`default_nettype none

module icache_top
    import icache_bus_pkg::*;
    import icache_geom_pkg::*;
#(
    parameter int IDX_W = DEF_IDX_W
) (
    input  logic                i_clk,
    input  logic                i_rst,
    input  logic                i_req,
    input  logic                i_submit,
    input  logic [RW-1:0]       i_addr,
    input  logic                i_flush,
    output logic                o_ack,
    output logic [I_SIZE-1:0]   o_data,
    output logic                o_wb_cyc,
    output logic                o_wb_stb,
    output logic [BUS_AW-1:0]   o_wb_adr,
    input  logic [RW-1:0]       i_wb_dat,
    input  logic                i_wb_ack,
    input  logic                i_wb_err
);

    localparam int TAG_W = RW - IDX_W - OFF_W;

    logic                refill_start;
    logic [RW-OFF_W-1:0] line_addr;
    logic                refill_busy;
    logic                fetch_end;
    logic                bus_err;
    icache_line_u        fill_line;

    logic [IDX_W-1:0]    ram_index;
    logic                ram_we;
    logic                ram_clear;
    logic [TAG_W-1:0]    ram_wr_tag;
    icache_line_u        ram_wr_line;
    logic [TAG_W-1:0]    ram_rd_tag;
    icache_line_u        ram_rd_line;
    logic                ram_valid;

    icache #(
        .IDX_W(IDX_W)
    ) u_ctrl (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_req          (i_req),
        .i_submit       (i_submit),
        .i_flush        (i_flush),
        .i_addr         (i_addr),
        .o_ack          (o_ack),
        .o_data         (o_data),
        .o_refill_start (refill_start),
        .o_line_addr    (line_addr),
        .i_refill_busy  (refill_busy),
        .i_fetch_end    (fetch_end),
        .i_bus_err      (bus_err),
        .i_fill_line    (fill_line),
        .o_ram_index    (ram_index),
        .o_ram_we       (ram_we),
        .o_ram_clear    (ram_clear),
        .o_ram_tag      (ram_wr_tag),
        .o_ram_line     (ram_wr_line),
        .i_ram_tag      (ram_rd_tag),
        .i_ram_line     (ram_rd_line),
        .i_ram_valid    (ram_valid)
    );

    icache_refill #(
        .IDX_W(IDX_W)
    ) u_refill (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_start     (refill_start),
        .i_line_addr (line_addr),
        .i_wb_dat    (i_wb_dat),
        .i_wb_ack    (i_wb_ack),
        .i_wb_err    (i_wb_err),
        .o_wb_cyc    (o_wb_cyc),
        .o_wb_stb    (o_wb_stb),
        .o_wb_adr    (o_wb_adr),
        .o_busy      (refill_busy),
        .o_fetch_end (fetch_end),
        .o_line      (fill_line),
        .o_bus_err   (bus_err)
    );

    icache_ram #(
        .IDX_W(IDX_W)
    ) u_ram (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_clear (ram_clear),
        .i_index (ram_index),
        .i_we    (ram_we),
        .i_tag   (ram_wr_tag),
        .i_line  (ram_wr_line),
        .o_tag   (ram_rd_tag),
        .o_line  (ram_rd_line),
        .o_valid (ram_valid)
    );

endmodule

`default_nettype wire

// ==== tb_icache_top.sv ====
`default_nettype none

module tb_icache_top
    import icache_bus_pkg::*;
    import icache_geom_pkg::*;
();

    localparam int IDX_W = DEF_IDX_W;
    localparam int TAG_W = RW - IDX_W - OFF_W;
    localparam int LINES = 1 << IDX_W;
    localparam int NUM_REQ = 600;
    localparam int TIMEOUT = 200;

    logic i_clk, i_rst, i_req, i_submit, i_flush;
    logic [RW-1:0] i_addr;
    logic o_ack, o_wb_cyc, o_wb_stb;
    logic [I_SIZE-1:0] o_data;
    logic [BUS_AW-1:0] o_wb_adr;
    logic [RW-1:0] i_wb_dat;
    logic i_wb_ack, i_wb_err;

    integer seed;
    logic [RW-1:0] req_q[$];
    logic [LINES-1:0] model_valid;
    logic [TAG_W-1:0] model_tag [LINES];
    logic [RW-OFF_W-1:0] refill_la;
    logic cyc_prev, refill_err, refill_cancel, timed_out;
    int mismatches, failures, stall, gap, beat_cnt, issued;
    int n_hits, n_refills, n_err_refills, n_cancelled, n_busy_submits, n_held_submits;

    icache_top #(
        .IDX_W(IDX_W)
    ) DUT (
        .i_clk(i_clk), .i_rst(i_rst), .i_req(i_req), .i_submit(i_submit),
        .i_addr(i_addr), .i_flush(i_flush), .o_ack(o_ack), .o_data(o_data),
        .o_wb_cyc(o_wb_cyc), .o_wb_stb(o_wb_stb), .o_wb_adr(o_wb_adr),
        .i_wb_dat(i_wb_dat), .i_wb_ack(i_wb_ack), .i_wb_err(i_wb_err)
    );

    initial i_clk = 1'b0;
    always #2 i_clk = ~i_clk;

    // Backing memory seen by the refill bus.
    function automatic logic [RW-1:0] mem_word(input logic [BUS_AW-1:0] a);
        logic [31:0] prod;
        prod = 32'(a) * 32'h9e37 + 32'h5a5a;
        return prod[RW-1:0];
    endfunction

    // Low half from beat offset*2 and high half from the beat after it.
    function automatic logic [I_SIZE-1:0] expected_instr(input logic [RW-1:0] a);
        logic [BUS_AW-1:0] base;
        base = {a[RW-1:OFF_W], a[OFF_W-1:0], 1'b0};
        return {mem_word(base + 1'b1), mem_word(base)};
    endfunction

    function automatic logic [IDX_W-1:0] line_index(input logic [RW-1:0] a);
        return a[OFF_W +: IDX_W];
    endfunction

    function automatic logic [TAG_W-1:0] line_tag(input logic [RW-1:0] a);
        return a[RW-1 -: TAG_W];
    endfunction

    function automatic logic model_holds(input logic [RW-1:0] a);
        return model_valid[line_index(a)] && (model_tag[line_index(a)] == line_tag(a));
    endfunction

    // Few tags and indexes so lines are reused and evicted often.
    function automatic logic [RW-1:0] pick_addr();
        logic [TAG_W-1:0] tag;
        logic [IDX_W-1:0] idx;
        logic [OFF_W-1:0] off;
        case ($unsigned($random(seed)) % 3)
            0: tag = 9'h000;
            1: tag = 9'h1a3;
            default: tag = 9'h0f5;
        endcase
        idx = IDX_W'(($unsigned($random(seed)) % 4) * 9);
        off = OFF_W'($random(seed));
        return {tag, idx, off};
    endfunction

    task automatic check_data(input string name, input logic [I_SIZE-1:0] exp,
                              input logic [I_SIZE-1:0] act);
        if (act !== exp) begin
            $display("mismatch %s: expected %h, actual %h", name, exp, act);
            mismatches++;
        end
    endtask

    task automatic check_addr(input string name, input logic [BUS_AW-1:0] exp,
                              input logic [BUS_AW-1:0] act);
        if (act !== exp) begin
            $display("mismatch %s: expected %h, actual %h", name, exp, act);
            mismatches++;
        end
    endtask

    task automatic check_refill_count(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("mismatch %s: expected %0d, actual %0d", name, exp, act);
            mismatches++;
        end
    endtask

    task automatic report_failure(input string msg);
        $display("error: %s", msg);
        failures++;
    endtask

    // Ack or err each beat after a random gap of 0 to 3 cycles.
    task automatic drive_bus();
        i_wb_ack = 1'b0;
        i_wb_err = 1'b0;
        i_wb_dat = '0;
        if (o_wb_cyc && o_wb_stb) begin
            if (gap == 0) begin
                if (($unsigned($random(seed)) % 16) == 0) begin
                    i_wb_err = 1'b1;
                end else begin
                    i_wb_ack = 1'b1;
                end
                i_wb_dat = mem_word(o_wb_adr);
                gap = $unsigned($random(seed)) % 4;
            end else begin
                gap--;
            end
        end
    endtask

    task automatic step_cycle();
        @(posedge i_clk);
        #1;
        i_submit = 1'b0;
        i_flush = 1'b0;
        drive_bus();
        if (stall >= TIMEOUT && !timed_out) begin
            report_failure("timeout, no ack for 200 cycles with requests outstanding");
            timed_out = 1'b1;
        end
    endtask

    // Outputs are sampled mid-cycle where they are settled.
    always @(negedge i_clk) begin
        logic [RW-1:0] a;
        if (i_rst) begin
            cyc_prev = 1'b0;
            stall = 0;
        end else begin
            if (o_wb_stb !== o_wb_cyc) begin
                report_failure("bus strobe and bus cycle differ");
            end
            if (o_wb_cyc && !cyc_prev) begin
                if (req_q.size() == 0) begin
                    report_failure("bus cycle started with no request outstanding");
                end else begin
                    if (model_holds(req_q[0])) begin
                        report_failure("refill started for a line that should hit");
                    end
                    refill_la = req_q[0][RW-1:OFF_W];
                end
                beat_cnt = 0;
                refill_err = 1'b0;
                refill_cancel = 1'b0;
            end
            if (i_flush) begin
                model_valid = '0;
                if (o_wb_cyc) begin
                    refill_cancel = 1'b1;
                end
            end
            if (o_wb_cyc && o_wb_stb && (i_wb_ack || i_wb_err)) begin
                check_addr("refill_addr", {refill_la, BEAT_W'(beat_cnt)}, o_wb_adr);
                beat_cnt++;
                refill_err = refill_err | i_wb_err;
            end
            if (o_ack && req_q.size() == 0) begin
                report_failure("ack with no request outstanding");
            end else if (o_ack) begin
                a = req_q.pop_front();
                check_data("data", expected_instr(a), o_data);
                if (o_wb_cyc) begin
                    check_refill_count("refill_count", BEATS, beat_cnt);
                    n_refills++;
                    n_err_refills += int'(refill_err);
                    n_cancelled += int'(refill_cancel);
                    if (!refill_err && !refill_cancel) begin
                        model_valid[line_index(a)] = 1'b1;
                        model_tag[line_index(a)] = line_tag(a);
                    end
                end else begin
                    if (!model_holds(a)) begin
                        report_failure("hit on a line that should refill");
                    end
                    n_hits++;
                end
            end
            stall = (o_ack || req_q.size() == 0) ? 0 : stall + 1;
            cyc_prev = o_wb_cyc;
        end
    end

    initial begin
        int waited;
        logic idle;
        logic may_submit;
        seed = 32'he32cf8a9;
        {i_rst, i_req, i_submit, i_flush, i_wb_ack, i_wb_err} = 6'b100000;
        i_addr = '0;
        i_wb_dat = '0;
        model_valid = '0;
        {mismatches, failures, stall, gap, beat_cnt, issued} = '0;
        {n_hits, n_refills, n_err_refills, n_cancelled, n_busy_submits, n_held_submits} = '0;
        {refill_la, cyc_prev, refill_err, refill_cancel, timed_out} = '0;
        repeat (5) @(posedge i_clk);
        #1;
        i_rst = 1'b0;
        if (o_ack !== 1'b0 || o_wb_cyc !== 1'b0 || o_wb_stb !== 1'b0) begin
            report_failure("ack or bus strobes not low after reset");
        end

        // At most one submit waits beside a refill because only one is held.
        while (issued < NUM_REQ && !timed_out) begin
            step_cycle();
            idle = (req_q.size() == 0);
            may_submit = idle || (req_q.size() == 1 && o_wb_cyc);
            i_req = ($unsigned($random(seed)) % 4) != 0;
            if (may_submit && ($unsigned($random(seed)) % 3) == 0) begin
                i_submit = 1'b1;
                i_addr = pick_addr();
                req_q.push_back(i_addr);
                issued++;
                if (o_wb_cyc) begin
                    n_busy_submits++;
                end else if (!i_req) begin
                    n_held_submits++;
                end
            end
            if ((idle || o_wb_cyc) && ($unsigned($random(seed)) % 64) == 0) begin
                i_flush = 1'b1;
            end
        end

        waited = 0;
        while (req_q.size() != 0 && waited < TIMEOUT && !timed_out) begin
            step_cycle();
            i_req = 1'b1;
            waited++;
        end
        if (req_q.size() != 0 && !timed_out) begin
            report_failure("requests still outstanding 200 cycles after the last submit");
        end

        if (n_hits == 0 || n_err_refills == 0 || n_cancelled == 0) begin
            report_failure("hits, bus errors or flushed refills were never exercised");
        end
        if (n_busy_submits == 0 || n_held_submits == 0) begin
            report_failure("submits during a refill or with i_req low were never exercised");
        end
        $display("requests %0d, hits %0d, refills %0d, with error %0d, flushed %0d",
                 issued, n_hits, n_refills, n_err_refills, n_cancelled);
        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire
